//--- project.f
verilog/hl_ctrl_pkg.sv
verilog/hl_cmd_if.sv
verilog/cmd_port.sv
verilog/cmd_regs.sv
verilog/tick_gen.sv
verilog/status_leds.sv
verilog/hl_ctrl_top.sv
tests/tb_hl_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_hl_ctrl -f project.f -o tb_hl_ctrl \
  && ./obj_dir/tb_hl_ctrl > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "tests failed" "$LOG" && exit 1 || grep -q "all tests passed" "$LOG"

//--- tests/tb_hl_ctrl.sv
// random-stimulus testbench for the control-plane slice
// a cycle model tracks registers, sticky flags, responses and ticks
// inputs change on the rising edge and outputs are checked on the falling edge
// ends with an error count and a pass or fail line

module tb_hl_ctrl import hl_ctrl_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CMDS  = 400;
  localparam int RST_CYC   = 4;
  localparam int MS_CYCLES = QMSEC_CYCLES * QMSEC_PER_MSEC;
  localparam int TIMEOUT_CYCLES =
    2 * (NUM_CMDS * 4 + 4 * LED_HOLD_MS * QMSEC_PER_MSEC * QMSEC_CYCLES);

  logic                  clk_ctrl;
  logic                  rst_n_i;
  logic                  cmd_valid_i;
  logic                  cmd_ready_o;
  logic [CMD_ADDR_W-1:0] cmd_addr_i;
  logic [CMD_DATA_W-1:0] cmd_data_i;
  logic                  cmd_requires_resp_i;
  logic                  resp_valid_o;
  logic                  resp_ready_i;
  logic [RESP_W-1:0]     resp_o;
  logic                  rxclip_i;
  logic                  rxgoodlvl_i;
  logic [7:0]            dsiq_status_i;
  logic                  io_tx_inhibit_i;
  logic                  io_alternate_mac_i;
  logic                  run_o;
  logic                  wide_spectrum_o;
  logic                  tx_on_o;
  logic [31:0]           static_ip_o;
  logic [47:0]           local_mac_o;
  logic [7:0]            eeprom_config_o;
  logic                  msec_pulse_o;
  logic                  qmsec_pulse_o;
  logic                  io_led_run_o;
  logic                  io_led_tx_o;
  logic                  io_led_adc75_o;
  logic                  io_led_adc100_o;

  // model state
  logic        m_run, m_wide, m_ptt, m_rvalid, m_clip, m_good;
  logic        m_led_run, m_led_tx, prev_clip, prev_good, tick_live;
  logic [31:0] m_ip;
  logic [15:0] m_alt;
  logic [7:0]  m_ee;
  logic [RESP_W-1:0] exp_q[$];

  integer seed;
  int     errors, n_accepted, n_rsp_sent, n_rsp_seen, timeout_cnt;
  int     since_q, q_pulses, ms_pulses, live_cycles;

  hl_ctrl_top UUT (.*);

  always #50 clk_ctrl = ~clk_ctrl;

  always @(posedge clk_ctrl) begin
    timeout_cnt = timeout_cnt + 1;
    if (timeout_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("%0d errors", errors);
      $display("tests failed");
      $finish;
    end
  end

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors = errors + 1;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  function automatic logic adc_led(input logic use_clip);
    return use_clip ? io_led_adc100_o : io_led_adc75_o;
  endfunction

  ////////////////////////////////////////
  // per-cycle check and model step

  task automatic check_cycle();
    logic              exp_ready, acc, rsp_acc, exp_tx, exp_msec;
    logic [31:0]       exp_status;
    logic [47:0]       exp_mac;
    logic [RESP_W-1:0] exp_resp;
    @(negedge clk_ctrl);
    exp_ready  = ~m_rvalid | resp_ready_i;
    acc        = cmd_valid_i & exp_ready;
    rsp_acc    = acc & cmd_requires_resp_i;
    exp_tx     = m_ptt & m_run & ~io_tx_inhibit_i;
    exp_status = {VERSION_MAJOR, VERSION_MINOR, dsiq_status_i, 4'h0,
                  exp_tx, m_run, m_good, m_clip};
    // board mac with either the low half or bit 1 replaced
    exp_mac = BASE_MAC;
    if (m_ee[EE_ALT_MAC_BIT]) begin
      exp_mac[15:0] = m_alt;
    end else begin
      exp_mac[1] = ~io_alternate_mac_i;
    end
    check_value(64'(cmd_ready_o), 64'(exp_ready), "cmd_ready_o");
    check_value(64'(run_o), 64'(m_run), "run_o");
    check_value(64'(wide_spectrum_o), 64'(m_wide), "wide_spectrum_o");
    check_value(64'(tx_on_o), 64'(exp_tx), "tx_on_o");
    check_value(64'(static_ip_o), 64'(m_ip), "static_ip_o");
    check_value(64'(eeprom_config_o), 64'(m_ee), "eeprom_config_o");
    check_value(64'(local_mac_o), 64'(exp_mac), "local_mac_o");
    check_value(64'(resp_valid_o), 64'(m_rvalid), "resp_valid_o");
    check_value(64'(io_led_run_o), 64'(m_led_run), "io_led_run_o");
    check_value(64'(io_led_tx_o), 64'(m_led_tx), "io_led_tx_o");
    // a level hit last cycle must show now
    if (prev_clip) check_value(64'(io_led_adc100_o), 64'd1, "io_led_adc100_o");
    if (prev_good) check_value(64'(io_led_adc75_o), 64'd1, "io_led_adc75_o");
    if (resp_valid_o && resp_ready_i) begin
      if (exp_q.size() == 0) begin
        errors = errors + 1;
        $display("unexpected response at %0t ns with none outstanding", $time);
      end else begin
        exp_resp = exp_q.pop_front();
        check_value(64'(resp_o), 64'(exp_resp), "resp_o");
      end
      n_rsp_seen = n_rsp_seen + 1;
    end
    // tick spacing in clock edges since reset release
    if (tick_live) begin
      since_q     = since_q + 1;
      live_cycles = live_cycles + 1;
    end
    tick_live = 1'b1;
    exp_msec  = qmsec_pulse_o & (((q_pulses + 1) % QMSEC_PER_MSEC) == 0);
    check_value(64'(msec_pulse_o), 64'(exp_msec), "msec_pulse_o");
    if (qmsec_pulse_o) begin
      check_value(64'(since_q), 64'(QMSEC_CYCLES), "qmsec pulse spacing");
      since_q  = 0;
      q_pulses = q_pulses + 1;
    end
    if (msec_pulse_o) ms_pulses = ms_pulses + 1;

    // next state
    if (rsp_acc) begin
      exp_q.push_back({2'b00, cmd_addr_i, exp_status});
      n_rsp_sent = n_rsp_sent + 1;
    end
    m_rvalid  = rsp_acc ? 1'b1 : (resp_ready_i ? 1'b0 : m_rvalid);
    m_led_run = m_run;
    m_led_tx  = exp_tx;
    m_clip    = rsp_acc ? rxclip_i : (m_clip | rxclip_i);
    m_good    = rsp_acc ? rxgoodlvl_i : (m_good | rxgoodlvl_i);
    prev_clip = rxclip_i;
    prev_good = rxgoodlvl_i;
    if (acc) begin
      n_accepted = n_accepted + 1;
      case (cmd_addr_i)
        ADDR_GENERAL: begin
          m_run  = cmd_data_i[0];
          m_wide = cmd_data_i[1];
          m_ptt  = cmd_data_i[2];
        end
        ADDR_STATIC_IP: m_ip = cmd_data_i;
        ADDR_NET_CFG: begin
          m_alt = cmd_data_i[15:0];
          m_ee  = cmd_data_i[31:24];
        end
        default: ;
      endcase
    end
  endtask

  ////////////////////////////////////////
  // stimulus

  task automatic drive_random();
    logic [31:0]           r;
    logic [CMD_ADDR_W-1:0] a;
    r = $random(seed);
    case (r[1:0])
      2'd0: a = ADDR_GENERAL;
      2'd1: a = ADDR_STATIC_IP;
      2'd2: a = ADDR_NET_CFG;
      default: a = r[7:2];
    endcase
    cmd_valid_i         <= (r[9:8] != 2'b00);
    cmd_addr_i          <= a;
    cmd_data_i          <= $random(seed);
    cmd_requires_resp_i <= r[10];
    resp_ready_i        <= (r[12:11] != 2'b00);
    rxclip_i            <= (r[15:13] == 3'b000);
    rxgoodlvl_i         <= (r[18:16] == 3'b000);
    dsiq_status_i       <= r[26:19];
    io_tx_inhibit_i     <= (r[28:27] == 2'b00);
    io_alternate_mac_i  <= r[29];
  endtask

  task automatic drive_idle(input logic clip, input logic good);
    cmd_valid_i  <= 1'b0;
    resp_ready_i <= 1'b1;
    rxclip_i     <= clip;
    rxgoodlvl_i  <= good;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_ctrl);
      drive_idle(1'b0, 1'b0);
      check_cycle();
    end
  endtask

  // single level hit and the stretch after it
  task automatic led_stretch(input logic use_clip);
    int gap;
    gap = (LED_HOLD_MS + 1) * MS_CYCLES + 1 + ($unsigned($random(seed)) % MS_CYCLES);
    idle_cycles(gap);
    check_value(64'(adc_led(use_clip)), 64'd0, "adc led before a level hit");
    @(posedge clk_ctrl);
    drive_idle(use_clip, ~use_clip);
    check_cycle();
    idle_cycles(1);
    check_value(64'(adc_led(use_clip)), 64'd1, "adc led after a level hit");
    idle_cycles((LED_HOLD_MS - 1) * MS_CYCLES);
    check_value(64'(adc_led(use_clip)), 64'd1, "adc led inside the hold time");
    idle_cycles(2 * MS_CYCLES + 2);
    check_value(64'(adc_led(use_clip)), 64'd0, "adc led after the hold time");
  endtask

  initial begin
    seed        = 32'h88f8;
    errors      = 0;
    timeout_cnt = 0;
    n_accepted  = 0;
    n_rsp_sent  = 0;
    n_rsp_seen  = 0;
    since_q     = 0;
    q_pulses    = 0;
    ms_pulses   = 0;
    live_cycles = 0;
    tick_live   = 1'b0;
    {m_run, m_wide, m_ptt, m_rvalid, m_clip, m_good} = '0;
    {m_led_run, m_led_tx, prev_clip, prev_good} = '0;
    m_ip  = '0;
    m_alt = '0;
    m_ee  = '0;
    clk_ctrl            = 1'b0;
    rst_n_i             = 1'b0;
    cmd_valid_i         = 1'b0;
    cmd_addr_i          = '0;
    cmd_data_i          = '0;
    cmd_requires_resp_i = 1'b0;
    resp_ready_i        = 1'b0;
    rxclip_i            = 1'b0;
    rxgoodlvl_i         = 1'b0;
    dsiq_status_i       = '0;
    io_tx_inhibit_i     = 1'b0;
    io_alternate_mac_i  = 1'b0;
    repeat (RST_CYC) @(posedge clk_ctrl);
    rst_n_i <= 1'b1;
    check_cycle();

    // random commands under back-pressure
    while (n_accepted < NUM_CMDS) begin
      @(posedge clk_ctrl);
      drive_random();
      check_cycle();
    end
    idle_cycles(4);
    check_value(64'(exp_q.size()), 64'd0, "responses still outstanding");
    check_value(64'(n_rsp_seen), 64'(n_rsp_sent), "response count");

    led_stretch(1'b1);
    led_stretch(1'b0);

    check_value(64'(q_pulses), 64'(live_cycles / QMSEC_CYCLES), "qmsec pulse count");
    check_value(64'(ms_pulses), 64'(q_pulses / QMSEC_PER_MSEC), "msec pulse count");
    $display("%0d commands, %0d responses, %0d errors", n_accepted, n_rsp_seen, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- verilog/cmd_port.sv
// host side of the command path
// accepts commands on valid/ready and passes them on as one-cycle strobes
// a command that wants a response loads a 40-bit word that is held
// until the host takes it; commands stall while it waits

module cmd_port import hl_ctrl_pkg::*; (
  input  logic                  clk_ctrl,
  input  logic                  rst_n_i,

  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  logic [CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [CMD_DATA_W-1:0] cmd_data_i,
  input  logic                  cmd_requires_resp_i,

  output logic                  resp_valid_o,
  input  logic                  resp_ready_i,
  output logic [RESP_W-1:0]     resp_o,

  hl_cmd_if.port                cif
);

  logic              accept;
  logic              resp_valid_q;
  logic [RESP_W-1:0] resp_q;

  ////////////////////////////////////////
  // command handshake

  // room when nothing is held or the held word leaves this cycle
  assign cmd_ready_o = ~resp_valid_q | resp_ready_i;
  assign accept      = cmd_valid_i & cmd_ready_o;

  assign cif.wr   = accept;
  assign cif.rsp  = accept & cmd_requires_resp_i;
  assign cif.addr = cmd_addr_i;
  assign cif.data = cmd_data_i;

  ////////////////////////////////////////
  // response holding register

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (cif.rsp) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  // status is sampled in the accept cycle, so it reflects the
  // registers before this command lands
  always_ff @(posedge clk_ctrl) begin
    if (cif.rsp) begin
      resp_q <= {2'b00, cmd_addr_i, cif.status};
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule

//--- verilog/cmd_regs.sv
// settings register file written by accepted host commands
// holds run, wide spectrum, ptt, static ip, alternate mac and eeprom
// config, picks the local mac and keeps the sticky receive level flags
// the status word it builds goes back to the command port

module cmd_regs import hl_ctrl_pkg::*; (
  input  logic        clk_ctrl,
  input  logic        rst_n_i,

  input  logic        rxclip_i,
  input  logic        rxgoodlvl_i,
  input  logic [7:0]  dsiq_status_i,
  input  logic        io_tx_inhibit_i,
  input  logic        io_alternate_mac_i,

  output logic        run_o,
  output logic        wide_spectrum_o,
  output logic        tx_on_o,
  output logic [31:0] static_ip_o,
  output logic [7:0]  eeprom_config_o,
  output logic [47:0] local_mac_o,

  hl_cmd_if.regs      cif
);

  logic        ptt_q;
  logic [15:0] alt_mac_q;
  logic        clip_q;
  logic        good_q;

  ////////////////////////////////////////
  // register writes

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_o           <= 1'b0;
      wide_spectrum_o <= 1'b0;
      ptt_q           <= 1'b0;
      static_ip_o     <= '0;
      alt_mac_q       <= '0;
      eeprom_config_o <= '0;
    end else if (cif.wr) begin
      case (cif.addr)
        ADDR_GENERAL: begin
          run_o           <= cif.data.ctl.run;
          wide_spectrum_o <= cif.data.ctl.wide_spectrum;
          ptt_q           <= cif.data.ctl.ptt;
        end
        ADDR_STATIC_IP: begin
          static_ip_o <= cif.data;
        end
        ADDR_NET_CFG: begin
          alt_mac_q       <= cif.data.net.alt_mac;
          eeprom_config_o <= cif.data.net.eeprom_config;
        end
        // anything else is ignored
        default: ;
      endcase
    end
  end

  // transmit only while running and not inhibited
  assign tx_on_o = ptt_q & run_o & ~io_tx_inhibit_i;

  ////////////////////////////////////////
  // mac selection

  // alternate mac replaces the low 16 bits, otherwise the jumper
  // flips bit 1 of the board mac
  assign local_mac_o = eeprom_config_o[EE_ALT_MAC_BIT]
                     ? {BASE_MAC[47:16], alt_mac_q}
                     : {BASE_MAC[47:2], ~io_alternate_mac_i, BASE_MAC[0]};

  ////////////////////////////////////////
  // sticky level flags

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clip_q <= 1'b0;
      good_q <= 1'b0;
    end else if (cif.rsp) begin
      // reported this cycle, restart from the current input
      clip_q <= rxclip_i;
      good_q <= rxgoodlvl_i;
    end else begin
      clip_q <= clip_q | rxclip_i;
      good_q <= good_q | rxgoodlvl_i;
    end
  end

  // status word
  assign cif.status = {VERSION_MAJOR, VERSION_MINOR, dsiq_status_i,
                       4'b0000, tx_on_o, run_o, good_q, clip_q};

endmodule

//--- verilog/hl_cmd_if.sv
// accepted commands and the live status word between the command port
// and the settings register file
// wr marks every accepted command, rsp only those that want a response

interface hl_cmd_if import hl_ctrl_pkg::*; ();

  logic [CMD_ADDR_W-1:0] addr;
  hl_cmd_word_u          data;
  // one-cycle accept strobe
  logic                  wr;
  // accept strobe of a command requiring a response
  logic                  rsp;
  // status word for the response
  logic [CMD_DATA_W-1:0] status;

  modport port (
    output addr,
    output data,
    output wr,
    output rsp,
    input  status
  );

  modport regs (
    input  addr,
    input  data,
    input  wr,
    input  rsp,
    output status
  );

endinterface

//--- verilog/hl_ctrl_pkg.sv
// constants and the command word layout shared by the control slice
// modules pull these in with a wildcard import in their header
// the union gives the two decodings of a 32-bit command data word

package hl_ctrl_pkg;

  ////////////////////////////////////////
  // command and response widths

  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;
  localparam int RESP_W     = 40;

  ////////////////////////////////////////
  // register map

  // control word, run / wide spectrum / ptt
  localparam logic [CMD_ADDR_W-1:0] ADDR_GENERAL   = 6'h00;
  localparam logic [CMD_ADDR_W-1:0] ADDR_STATIC_IP = 6'h3A;
  // alternate mac low half plus eeprom config byte
  localparam logic [CMD_ADDR_W-1:0] ADDR_NET_CFG   = 6'h3B;

  // board mac 00:1c:c0:a2:13:dd
  localparam logic [47:0] BASE_MAC = 48'h001c_c0a2_13dd;

  // eeprom_config bit selecting the alternate mac
  localparam int EE_ALT_MAC_BIT = 6;

  localparam logic [7:0] VERSION_MAJOR = 8'd69;
  localparam logic [7:0] VERSION_MINOR = 8'd3;

  ////////////////////////////////////////
  // tick lengths

  // clk_ctrl runs at 2.5 MHz
  localparam int QMSEC_CYCLES   = 625;
  localparam int QMSEC_PER_MSEC = 4;
  localparam int LED_HOLD_MS    = 2;

  localparam int QMSEC_CNT_W = $clog2(QMSEC_CYCLES);
  localparam int QMSEC_IDX_W = $clog2(QMSEC_PER_MSEC);
  localparam int LED_HOLD_W  = $clog2(LED_HOLD_MS + 1);

  ////////////////////////////////////////
  // command data word

  typedef union packed {
    // view at ADDR_GENERAL
    struct packed {
      logic [CMD_DATA_W-4:0] rsvd;
      logic                  ptt;
      logic                  wide_spectrum;
      logic                  run;
    } ctl;
    // view at ADDR_NET_CFG
    struct packed {
      logic [7:0]  eeprom_config;
      logic [7:0]  rsvd;
      logic [15:0] alt_mac;
    } net;
  } hl_cmd_word_u;

endpackage

//--- verilog/hl_ctrl_top.sv
// top of the control-plane slice, everything on clk_ctrl
// host commands come in on a valid/ready port, responses leave on another
// settings, mac selection, ticks and front panel leds are driven from here

module hl_ctrl_top import hl_ctrl_pkg::*; (
  input  logic                  clk_ctrl,
  input  logic                  rst_n_i,

  // host command port
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  logic [CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [CMD_DATA_W-1:0] cmd_data_i,
  input  logic                  cmd_requires_resp_i,

  // response channel
  output logic                  resp_valid_o,
  input  logic                  resp_ready_i,
  output logic [RESP_W-1:0]     resp_o,

  // receive level and fifo status
  input  logic                  rxclip_i,
  input  logic                  rxgoodlvl_i,
  input  logic [7:0]            dsiq_status_i,

  input  logic                  io_tx_inhibit_i,
  input  logic                  io_alternate_mac_i,

  // settings
  output logic                  run_o,
  output logic                  wide_spectrum_o,
  output logic                  tx_on_o,
  output logic [31:0]           static_ip_o,
  output logic [47:0]           local_mac_o,
  output logic [7:0]            eeprom_config_o,

  // ticks
  output logic                  msec_pulse_o,
  output logic                  qmsec_pulse_o,

  // front panel
  output logic                  io_led_run_o,
  output logic                  io_led_tx_o,
  output logic                  io_led_adc75_o,
  output logic                  io_led_adc100_o
);

  hl_cmd_if cmd_if ();

  ////////////////////////////////////////
  // command / response

  cmd_port cmd_port_i (
    .clk_ctrl            (clk_ctrl),
    .rst_n_i             (rst_n_i),
    .cmd_valid_i         (cmd_valid_i),
    .cmd_ready_o         (cmd_ready_o),
    .cmd_addr_i          (cmd_addr_i),
    .cmd_data_i          (cmd_data_i),
    .cmd_requires_resp_i (cmd_requires_resp_i),
    .resp_valid_o        (resp_valid_o),
    .resp_ready_i        (resp_ready_i),
    .resp_o              (resp_o),
    .cif                 (cmd_if.port)
  );

  cmd_regs cmd_regs_i (
    .clk_ctrl           (clk_ctrl),
    .rst_n_i            (rst_n_i),
    .rxclip_i           (rxclip_i),
    .rxgoodlvl_i        (rxgoodlvl_i),
    .dsiq_status_i      (dsiq_status_i),
    .io_tx_inhibit_i    (io_tx_inhibit_i),
    .io_alternate_mac_i (io_alternate_mac_i),
    .run_o              (run_o),
    .wide_spectrum_o    (wide_spectrum_o),
    .tx_on_o            (tx_on_o),
    .static_ip_o        (static_ip_o),
    .eeprom_config_o    (eeprom_config_o),
    .local_mac_o        (local_mac_o),
    .cif                (cmd_if.regs)
  );

  ////////////////////////////////////////
  // control

  tick_gen tick_gen_i (
    .clk_ctrl      (clk_ctrl),
    .rst_n_i       (rst_n_i),
    .qmsec_pulse_o (qmsec_pulse_o),
    .msec_pulse_o  (msec_pulse_o)
  );

  status_leds status_leds_i (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .msec_pulse_i    (msec_pulse_o),
    .run_i           (run_o),
    .tx_on_i         (tx_on_o),
    .rxclip_i        (rxclip_i),
    .rxgoodlvl_i     (rxgoodlvl_i),
    .io_led_run_o    (io_led_run_o),
    .io_led_tx_o     (io_led_tx_o),
    .io_led_adc75_o  (io_led_adc75_o),
    .io_led_adc100_o (io_led_adc100_o)
  );

endmodule

//--- verilog/status_leds.sv
// front panel leds
// run and tx follow the settings one cycle late
// the adc leds light on a level hit and stay lit for LED_HOLD_MS to
// LED_HOLD_MS+1 milliseconds after the last hit

module status_leds import hl_ctrl_pkg::*; (
  input  logic clk_ctrl,
  input  logic rst_n_i,
  input  logic msec_pulse_i,
  input  logic run_i,
  input  logic tx_on_i,
  input  logic rxclip_i,
  input  logic rxgoodlvl_i,
  output logic io_led_run_o,
  output logic io_led_tx_o,
  output logic io_led_adc75_o,
  output logic io_led_adc100_o
);

  // index 1 clip, index 0 good level
  logic [1:0] adc_hit;
  logic [1:0] adc_led;

  assign adc_hit = {rxclip_i, rxgoodlvl_i};

  ////////////////////////////////////////
  // run and tx

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      io_led_run_o <= 1'b0;
      io_led_tx_o  <= 1'b0;
    end else begin
      io_led_run_o <= run_i;
      io_led_tx_o  <= tx_on_i;
    end
  end

  ////////////////////////////////////////
  // adc level stretch

  for (genvar i = 0; i < 2; i++) begin : g_adc
    logic [LED_HOLD_W-1:0] hold_cnt;
    logic                  led_q;

    always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
      if (!rst_n_i) begin
        hold_cnt <= '0;
        led_q    <= 1'b0;
      end else if (adc_hit[i]) begin
        hold_cnt <= LED_HOLD_W'(LED_HOLD_MS);
        led_q    <= 1'b1;
      end else if (msec_pulse_i) begin
        // first msec tick after the count runs out turns it off
        if (hold_cnt != '0) begin
          hold_cnt <= hold_cnt - 1'b1;
        end else begin
          led_q <= 1'b0;
        end
      end
    end

    assign adc_led[i] = led_q;
  end

  assign io_led_adc100_o = adc_led[1];
  assign io_led_adc75_o  = adc_led[0];

endmodule

//--- verilog/tick_gen.sv
// quarter-millisecond and millisecond pulses from clk_ctrl
// each pulse is one cycle wide; msec lands on every fourth qmsec

module tick_gen import hl_ctrl_pkg::*; (
  input  logic clk_ctrl,
  input  logic rst_n_i,
  output logic qmsec_pulse_o,
  output logic msec_pulse_o
);

  logic [QMSEC_CNT_W-1:0] cyc_cnt;
  logic [QMSEC_IDX_W-1:0] q_cnt;
  logic                   cyc_wrap;
  logic                   q_wrap;

  assign cyc_wrap = (cyc_cnt == QMSEC_CNT_W'(QMSEC_CYCLES - 1));
  assign q_wrap   = (q_cnt == QMSEC_IDX_W'(QMSEC_PER_MSEC - 1));

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cyc_cnt       <= '0;
      q_cnt         <= '0;
      qmsec_pulse_o <= 1'b0;
      msec_pulse_o  <= 1'b0;
    end else begin
      qmsec_pulse_o <= cyc_wrap;
      msec_pulse_o  <= cyc_wrap & q_wrap;
      if (cyc_wrap) begin
        cyc_cnt <= '0;
        // quarter count advances once per qmsec
        q_cnt   <= q_wrap ? '0 : q_cnt + 1'b1;
      end else begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
    end
  end

endmodule
